// ==== project.f ====
source/eeprom_pkg.sv
source/line_sampler.sv
source/serial_slave.sv
source/mem_arbiter.sv
source/byte_store.sv
source/serial_eeprom_top.sv
verif/tb_serial_eeprom.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the serial EEPROM testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_serial_eeprom -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in sim.log"
exit 1

// ==== source/byte_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module byte_store import eeprom_pkg::*; (
    input  logic              sda,
    input  logic              store_en,
    input  logic              store_we,
    input  logic [addr_w-1:0] store_addr,
    input  logic [data_w-1:0] store_wdata,
    output logic [data_w-1:0] store_rdata
);

    logic [data_w-1:0] mem [mem_depth];

    initial
    begin
        for (int i = 0; i < mem_depth; i++)
            mem[i] = '0;  // blank part for simulation
    end

    always @(posedge sda)
    begin
        if (store_en && store_we)
            mem[store_addr] <= store_wdata;
    end

    always_ff @(posedge sda)
    begin
        if (store_en && !store_we)
            store_rdata <= mem[store_addr];
    end

endmodule

`default_nettype wire

// ==== source/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // memory geometry
    localparam int mem_depth = 2048;
    localparam int addr_w    = 11;
    localparam int data_w    = 8;

    localparam logic [3:0] dev_code = 4'b1010;  // control byte upper nibble

    // requester index and the arbiter's last-served flag
    localparam logic serial_port = 1'b0;
    localparam logic host_port   = 1'b1;

endpackage

`default_nettype wire

// ==== source/line_sampler.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_sampler (
    input  logic sda,
    input  logic rst_n,
    input  logic ser_clk,
    input  logic ser_data,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_seen,
    output logic stop_seen,
    output logic data_bit
);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       dat_prev;

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clk_sync <= 2'b11;  // released bus reads high
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
            dat_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ser_clk};
            dat_sync <= {dat_sync[0], ser_data};
            clk_prev <= clk_sync[1];
            dat_prev <= dat_sync[1];
        end
    end

    assign scl_rise = clk_sync[1] & ~clk_prev;
    assign scl_fall = ~clk_sync[1] & clk_prev;

    // data may only move while the clock is low, so a move with clock high is a condition
    assign start_seen = clk_sync[1] & clk_prev & dat_prev & ~dat_sync[1];
    assign stop_seen  = clk_sync[1] & clk_prev & ~dat_prev & dat_sync[1];

    assign data_bit = dat_sync[1];

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import eeprom_pkg::*; (
    input  logic              sda,
    input  logic              rst_n,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [addr_w-1:0] host_addr,
    input  logic [data_w-1:0] host_wdata,
    output logic [data_w-1:0] host_rdata,
    output logic              host_ack,
    input  logic              mem_req,
    input  logic              mem_we,
    input  logic [addr_w-1:0] mem_addr,
    input  logic [data_w-1:0] mem_wdata,
    output logic [data_w-1:0] mem_rdata,
    output logic              mem_ack,
    output logic              store_en,
    output logic              store_we,
    output logic [addr_w-1:0] store_addr,
    output logic [data_w-1:0] store_wdata,
    input  logic [data_w-1:0] store_rdata
);

    typedef enum logic [1:0] {
        a_idle,
        a_access,
        a_ack_high,
        a_wait_low
    } arb_state_t;

    arb_state_t state;
    logic       last_served;  // also the peer in service
    logic       pick;
    logic       any_req;
    logic       served_req;

    assign any_req = host_req | mem_req;

    // on contention the peer served last yields
    assign pick = (host_req && mem_req) ? ~last_served
                : (host_req ? host_port : serial_port);

    assign served_req = (last_served == host_port) ? host_req : mem_req;

    // store is only touched from idle, so the mux follows pick
    assign store_en    = state == a_idle && any_req;
    assign store_we    = (pick == host_port) ? host_we : mem_we;
    assign store_addr  = (pick == host_port) ? host_addr : mem_addr;
    assign store_wdata = (pick == host_port) ? host_wdata : mem_wdata;

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= a_idle;
            last_served <= host_port;  // serial first on a tie
            host_ack    <= 1'b0;
            mem_ack     <= 1'b0;
        end
        else
        begin
            case (state)
                a_idle:
                begin
                    host_ack <= 1'b0;  // ack drops one edge after req seen low
                    mem_ack  <= 1'b0;
                    if (any_req)
                    begin
                        last_served <= pick;
                        state       <= a_access;
                    end
                end
                a_access:
                    state <= a_ack_high;
                a_ack_high:
                begin
                    if (last_served == host_port)
                        host_ack <= 1'b1;
                    else
                        mem_ack <= 1'b1;
                    state <= a_wait_low;
                end
                a_wait_low:
                    if (!served_req)
                        state <= a_idle;
                default:
                    state <= a_idle;
            endcase
        end
    end

    always_ff @(posedge sda)
    begin
        if (state == a_access)
        begin
            if (last_served == host_port)
                host_rdata <= store_rdata;
            else
                mem_rdata <= store_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/serial_eeprom_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module serial_eeprom_top import eeprom_pkg::*; (
    input  logic              sda,
    input  logic              rst_n,
    input  logic              ser_clk,
    input  logic              ser_data,
    output logic              ser_data_low,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [addr_w-1:0] host_addr,
    input  logic [data_w-1:0] host_wdata,
    output logic [data_w-1:0] host_rdata,
    output logic              host_ack
);

    logic              scl_rise;
    logic              scl_fall;
    logic              start_seen;
    logic              stop_seen;
    logic              data_bit;

    logic              mem_req;
    logic              mem_we;
    logic [addr_w-1:0] mem_addr;
    logic [data_w-1:0] mem_wdata;
    logic [data_w-1:0] mem_rdata;
    logic              mem_ack;

    logic              store_en;
    logic              store_we;
    logic [addr_w-1:0] store_addr;
    logic [data_w-1:0] store_wdata;
    logic [data_w-1:0] store_rdata;

    line_sampler i_sampler (
        .sda        (sda),
        .rst_n      (rst_n),
        .ser_clk    (ser_clk),
        .ser_data   (ser_data),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .data_bit   (data_bit)
    );

    serial_slave i_slave (
        .sda          (sda),
        .rst_n        (rst_n),
        .scl_rise     (scl_rise),
        .scl_fall     (scl_fall),
        .start_seen   (start_seen),
        .stop_seen    (stop_seen),
        .data_bit     (data_bit),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .ser_data_low (ser_data_low),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    mem_arbiter i_arbiter (
        .sda         (sda),
        .rst_n       (rst_n),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .host_ack    (host_ack),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ack     (mem_ack),
        .store_en    (store_en),
        .store_we    (store_we),
        .store_addr  (store_addr),
        .store_wdata (store_wdata),
        .store_rdata (store_rdata)
    );

    byte_store i_store (
        .sda         (sda),
        .store_en    (store_en),
        .store_we    (store_we),
        .store_addr  (store_addr),
        .store_wdata (store_wdata),
        .store_rdata (store_rdata)
    );

endmodule

`default_nettype wire

// ==== source/serial_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module serial_slave import eeprom_pkg::*; (
    input  logic              sda,
    input  logic              rst_n,
    input  logic              scl_rise,
    input  logic              scl_fall,
    input  logic              start_seen,
    input  logic              stop_seen,
    input  logic              data_bit,
    input  logic              mem_ack,
    input  logic [data_w-1:0] mem_rdata,
    output logic              ser_data_low,
    output logic              mem_req,
    output logic              mem_we,
    output logic [addr_w-1:0] mem_addr,
    output logic [data_w-1:0] mem_wdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_control,
        st_address,
        st_write,
        st_read,
        st_ack,
        st_wait_stop
    } state_t;

    state_t                   state;
    state_t                   ack_next;   // state after the ack slot
    logic [3:0]               bit_cnt;
    logic [data_w-2:0]        shift;      // msb lives in next_byte or on the line
    logic [data_w-1:0]        next_byte;
    logic [data_w-1:0]        rd_buf;     // prefetched byte at ptr
    logic [addr_w-data_w-1:0] blk;
    logic [addr_w-1:0]        ptr;
    logic                     rx_bit;
    logic                     byte_done;
    logic                     ctrl_ok;
    logic                     start_write;
    logic                     start_prefetch;
    logic                     load_byte;
    logic                     tx_shift;

    assign next_byte = {shift, data_bit};
    assign ctrl_ok   = next_byte[7:4] == dev_code;

    assign rx_bit    = scl_rise
                     && (state == st_control || state == st_address || state == st_write);
    assign byte_done = rx_bit && bit_cnt == 4'd7;

    assign start_write = byte_done && state == st_write;

    // next read byte goes out on this fall
    assign load_byte = scl_fall
                     && ((state == st_ack && ser_data_low && ack_next == st_read)
                     ||  (state == st_read && bit_cnt == 4'd9));

    assign start_prefetch = (byte_done && state == st_control && ctrl_ok && next_byte[0])
                          || load_byte;

    assign tx_shift = scl_fall && state == st_read && bit_cnt != 4'd0 && bit_cnt < 4'd8;

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= st_idle;
            ack_next     <= st_idle;
            bit_cnt      <= '0;
            ptr          <= '0;
            ser_data_low <= 1'b0;
            mem_req      <= 1'b0;
            mem_we       <= 1'b0;
        end
        else
        begin
            if (mem_req && mem_ack)
                mem_req <= 1'b0;
            if (start_seen || stop_seen)
            begin
                state        <= start_seen ? st_control : st_idle;
                bit_cnt      <= '0;
                ser_data_low <= 1'b0;
            end
            else
            begin
                if (rx_bit)
                    bit_cnt <= byte_done ? 4'd0 : bit_cnt + 4'd1;
                case (state)
                    st_control:
                        if (byte_done)
                        begin
                            if (!ctrl_ok)
                                state <= st_idle;  // not ours so silent until start
                            else
                            begin
                                state    <= st_ack;
                                ack_next <= next_byte[0] ? st_read : st_address;
                                if (next_byte[0])
                                begin
                                    mem_req <= 1'b1;
                                    mem_we  <= 1'b0;
                                end
                            end
                        end
                    st_address:
                        if (byte_done)
                        begin
                            state    <= st_ack;
                            ack_next <= st_write;
                            ptr      <= {blk, next_byte};
                        end
                    st_write:
                        if (byte_done)
                        begin
                            state    <= st_ack;
                            ack_next <= st_write;
                            mem_req  <= 1'b1;
                            mem_we   <= 1'b1;
                            ptr      <= ptr + addr_w'(1);  // wraps at mem_depth
                        end
                    st_ack:
                        if (scl_fall)
                        begin
                            if (!ser_data_low)
                                ser_data_low <= 1'b1;
                            else
                            begin
                                state        <= ack_next;
                                bit_cnt      <= '0;
                                ser_data_low <= 1'b0;
                            end
                        end
                    st_read:
                        if (scl_rise)
                        begin
                            if (bit_cnt == 4'd8)
                            begin
                                if (data_bit)
                                    state <= st_wait_stop;  // master nack
                                else
                                    bit_cnt <= 4'd9;
                            end
                            else
                                bit_cnt <= bit_cnt + 4'd1;
                        end
                        else if (scl_fall)
                        begin
                            if (bit_cnt == 4'd8)
                                ser_data_low <= 1'b0;  // master's ack slot
                            else if (tx_shift)
                                ser_data_low <= ~shift[data_w-2];
                        end
                    default:
                    begin
                    end
                endcase
                // send rd_buf and fetch the byte after it
                if (load_byte)
                begin
                    ser_data_low <= ~rd_buf[data_w-1];
                    bit_cnt      <= '0;
                    ptr          <= ptr + addr_w'(1);
                    mem_req      <= 1'b1;
                    mem_we       <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (rx_bit)
            shift <= next_byte[data_w-2:0];
        else if (load_byte)
            shift <= rd_buf[data_w-2:0];
        else if (tx_shift)
            shift <= shift << 1;
        if (byte_done && state == st_control)
            blk <= next_byte[3:1];
        if (start_write)
        begin
            mem_wdata <= next_byte;
            mem_addr  <= ptr;
        end
        else if (start_prefetch)
            mem_addr <= load_byte ? ptr + addr_w'(1) : ptr;
        if (mem_req && mem_ack && !mem_we)
            rd_buf <= mem_rdata;
    end

endmodule

`default_nettype wire

// ==== verif/tb_serial_eeprom.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_serial_eeprom import eeprom_pkg::*; ();

    localparam int half_cycles = 8;  // sda cycles per ser_clk half period
    localparam int host_limit  = 100;

    logic              sda;
    logic              rst_n;
    logic              ser_clk;
    logic              master_data;
    logic              ser_data;
    logic              ser_data_low;
    logic              host_req;
    logic              host_we;
    logic [addr_w-1:0] host_addr;
    logic [data_w-1:0] host_wdata;
    logic [data_w-1:0] host_rdata;
    logic              host_ack;

    logic [data_w-1:0] shadow [mem_depth];
    logic [data_w-1:0] wr_buf [64];
    logic [addr_w-1:0] obs_addr [$];
    logic [data_w-1:0] obs_data [$];
    logic              obs_serial [$];
    logic [addr_w-1:0] chk_addr;
    logic [data_w-1:0] chk_got;
    logic              chk_serial;
    integer            seed;
    int                errors;
    int                checks;

    assign ser_data = master_data & ~ser_data_low;  // open-drain wired-AND

    serial_eeprom_top i_dut (
        .sda          (sda),
        .rst_n        (rst_n),
        .ser_clk      (ser_clk),
        .ser_data     (ser_data),
        .ser_data_low (ser_data_low),
        .host_req     (host_req),
        .host_we      (host_we),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .host_rdata   (host_rdata),
        .host_ack     (host_ack)
    );

    always #2 sda = ~sda;

    function automatic logic [data_w-1:0] expected_byte(input logic [addr_w-1:0] addr);
        return shadow[addr];
    endfunction

    always @(posedge sda)
    begin
        while (obs_addr.size() > 0)
        begin
            chk_addr   = obs_addr.pop_front();
            chk_got    = obs_data.pop_front();
            chk_serial = obs_serial.pop_front();
            checks++;
            if (chk_got !== expected_byte(chk_addr))
            begin
                errors++;
                if (chk_serial)
                    $display("FAIL ser_data at 0x%h: got 0x%h, expected 0x%h",
                             chk_addr, chk_got, expected_byte(chk_addr));
                else
                    $display("FAIL host_rdata at 0x%h: got 0x%h, expected 0x%h",
                             chk_addr, chk_got, expected_byte(chk_addr));
            end
        end
    end

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic ser_wait(input int n);
        repeat (n) @(posedge sda);
        #1;
    endtask

    // data moves mid low phase and the line is sampled mid high phase
    task automatic clock_bit(input logic drive, output logic line);
        ser_wait(half_cycles / 2);
        master_data = drive;
        ser_wait(half_cycles / 2);
        ser_clk = 1'b1;
        ser_wait(half_cycles / 2);
        line = ser_data;
        ser_wait(half_cycles / 2);
        ser_clk = 1'b0;
    endtask

    task automatic send_start();
        ser_wait(half_cycles / 2);
        master_data = 1'b1;
        ser_wait(half_cycles / 2);
        ser_clk = 1'b1;
        ser_wait(half_cycles);
        master_data = 1'b0;  // falls with clock high
        ser_wait(half_cycles);
        ser_clk = 1'b0;
    endtask

    task automatic send_stop();
        ser_wait(half_cycles / 2);
        master_data = 1'b0;
        ser_wait(half_cycles / 2);
        ser_clk = 1'b1;
        ser_wait(half_cycles);
        master_data = 1'b1;  // bus idle after this
        ser_wait(half_cycles);
    endtask

    task automatic ser_write_byte(input logic [data_w-1:0] value, input logic expect_ack);
        logic line;
        for (int i = data_w - 1; i >= 0; i--)
            clock_bit(value[i], line);
        clock_bit(1'b1, line);  // ack slot
        checks++;
        if (expect_ack && line)
        begin
            errors++;
            $display("no ack from the DUT after byte 0x%h", value);
        end
        else if (!expect_ack && !line)
        begin
            errors++;
            $display("the DUT acked byte 0x%h that it should ignore", value);
        end
    endtask

    task automatic ser_read_byte(input logic [addr_w-1:0] addr, input logic last);
        logic [data_w-1:0] value;
        logic              line;
        for (int i = data_w - 1; i >= 0; i--)
        begin
            clock_bit(1'b1, line);
            value[i] = line;
        end
        clock_bit(last, line);  // nack on the last byte
        obs_addr.push_back(addr);
        obs_data.push_back(value);
        obs_serial.push_back(1'b1);
    endtask

    task automatic fill_buf(input int n);
        logic [31:0] rnd;
        for (int k = 0; k < n; k++)
        begin
            rnd = $random(seed);
            wr_buf[k] = rnd[data_w-1:0];
        end
    endtask

    task automatic serial_write(input logic [addr_w-1:0] addr, input int n);
        logic [addr_w-1:0] a;
        a = addr;
        send_start();
        ser_write_byte({dev_code, addr[addr_w-1:data_w], 1'b0}, 1'b1);
        ser_write_byte(addr[data_w-1:0], 1'b1);
        for (int k = 0; k < n; k++)
        begin
            shadow[a] = wr_buf[k];
            ser_write_byte(wr_buf[k], 1'b1);
            a = a + addr_w'(1);  // wraps like the pointer
        end
        send_stop();
    endtask

    task automatic serial_read(input logic [addr_w-1:0] addr, input int n);
        logic [addr_w-1:0] a;
        a = addr;
        send_start();
        ser_write_byte({dev_code, addr[addr_w-1:data_w], 1'b0}, 1'b1);  // dummy write
        ser_write_byte(addr[data_w-1:0], 1'b1);
        send_start();
        ser_write_byte({dev_code, addr[addr_w-1:data_w], 1'b1}, 1'b1);
        for (int k = 0; k < n; k++)
        begin
            ser_read_byte(a, k == n - 1);
            a = a + addr_w'(1);
        end
        send_stop();
    endtask

    task automatic host_access(input logic we, input logic [addr_w-1:0] addr,
                               input logic [data_w-1:0] wdata);
        int cnt;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        if (we)
            shadow[addr] = wdata;
        cnt = 0;
        while (host_ack !== 1'b1 && cnt < host_limit)
        begin
            @(posedge sda);
            #1;
            cnt++;
        end
        if (host_ack !== 1'b1)
            report_timeout("host_ack to rise");
        else
        begin
            if (!we)
            begin
                obs_addr.push_back(addr);
                obs_data.push_back(host_rdata);
                obs_serial.push_back(1'b0);
            end
            host_req = 1'b0;
            cnt = 0;
            while (host_ack !== 1'b0 && cnt < host_limit)
            begin
                @(posedge sda);
                #1;
                cnt++;
            end
            if (host_ack !== 1'b0)
                report_timeout("host_ack to fall");
        end
    endtask

    initial
    begin
        logic [31:0]       rnd;
        logic [addr_w-1:0] base;
        logic [addr_w-1:0] a;
        seed        = 32'hd7d8;
        errors      = 0;
        checks      = 0;
        sda         = 1'b0;
        rst_n       = 1'b0;
        ser_clk     = 1'b1;
        master_data = 1'b1;
        host_req    = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        for (int i = 0; i < mem_depth; i++)
            shadow[i] = '0;
        repeat (4) @(posedge sda);
        #1;
        rst_n = 1'b1;
        ser_wait(2);

        // idle outputs and a blank part
        checks += 2;
        if (ser_data_low !== 1'b0)
        begin
            errors++;
            $display("FAIL ser_data_low: got 0x%h, expected 0x0", ser_data_low);
        end
        if (host_ack !== 1'b0)
        begin
            errors++;
            $display("FAIL host_ack: got 0x%h, expected 0x0", host_ack);
        end
        for (int k = 0; k < 8; k++)
        begin
            rnd = $random(seed);
            host_access(1'b0, rnd[addr_w-1:0], 8'h00);
        end

        // serial write, host read back
        rnd  = $random(seed);
        base = rnd[addr_w-1:0];
        fill_buf(8);
        serial_write(base, 8);
        a = base;
        for (int k = 0; k < 8; k++)
        begin
            host_access(1'b0, a, 8'h00);
            a = a + addr_w'(1);
        end

        // host writes, serial random read
        rnd  = $random(seed);
        base = rnd[addr_w-1:0];
        a    = base;
        for (int k = 0; k < 16; k++)
        begin
            rnd = $random(seed);
            host_access(1'b1, a, rnd[data_w-1:0]);
            a = a + addr_w'(1);
        end
        serial_read(base, 16);

        // foreign device code is ignored
        host_access(1'b1, 11'h055, 8'ha5);
        send_start();
        ser_write_byte({4'b1011, 3'b000, 1'b0}, 1'b0);
        ser_write_byte(8'h55, 1'b0);
        ser_write_byte(8'h3c, 1'b0);
        send_stop();
        host_access(1'b0, 11'h055, 8'h00);

        // pointer wrap at the top
        fill_buf(4);
        serial_write(11'h7fe, 4);
        host_access(1'b0, 11'h7fe, 8'h00);
        host_access(1'b0, 11'h7ff, 8'h00);
        host_access(1'b0, 11'h000, 8'h00);
        host_access(1'b0, 11'h001, 8'h00);

        // both peers at once on disjoint ranges
        fill_buf(40);
        fork
            serial_write(11'h200, 40);
            for (int k = 0; k < 200; k++)
            begin
                rnd = $random(seed);
                host_access(rnd[8], {3'b100, rnd[7:0]}, rnd[23:16]);
                ser_wait(int'(rnd[28:24]) + 1);
            end
        join
        serial_read(11'h200, 40);
        serial_read(11'h400, 32);

        ser_wait(4);
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
